/* design/FetchTypes.sv */
// Shared definitions for the instruction fetch subsystem
// Address and cache geometry, address and line types,
// page-table word layout and the fetch state enum
package FetchTypes;

    localparam int VirtualAddrWidth = 32;
    localparam int PhysicalAddrWidth = 24;
    localparam int PageOffsetWidth = 12;
    localparam int InsnSize = 4;

    localparam int LineWidth = 128;
    localparam int LineOffsetWidth = 4;
    localparam int ICacheIndexWidth = 4;
    localparam int ICacheTagWidth = 16;
    localparam int ICacheLines = 1 << ICacheIndexWidth;

    localparam int ITlbEntries = 4;
    localparam int ITlbIndexWidth = $clog2(ITlbEntries);

    localparam int VpnWidth = VirtualAddrWidth - PageOffsetWidth;
    localparam int PpnWidth = PhysicalAddrWidth - PageOffsetWidth;
    localparam int LineAddrWidth = PhysicalAddrWidth - LineOffsetWidth;

    // Page-table word layout, PPN in the low bits
    localparam int PteWidth = 32;
    localparam int PteSizeLog2 = 2;
    localparam int PteValidBit = 31;
    localparam int PteExecBit = 30;

    typedef logic [VirtualAddrWidth-1:0] vaddr_t;
    typedef logic [PhysicalAddrWidth-1:0] paddr_t;
    typedef logic [VpnWidth-1:0] vpn_t;
    typedef logic [PpnWidth-1:0] ppn_t;
    typedef logic [LineAddrWidth-1:0] lineAddr_t;
    typedef logic [LineWidth-1:0] line_t;
    typedef logic [ICacheIndexWidth-1:0] cacheIndex_t;
    typedef logic [ICacheTagWidth-1:0] cacheTag_t;
    typedef logic [PteWidth-1:0] pte_t;

    localparam vaddr_t InitialPc = 32'h0000_1000;

    typedef enum logic [1:0] {
        Fetch = 2'd0,
        RefillTlb = 2'd1,
        RefillCache = 2'd2
    } FetchState;

endpackage

/* design/MemReadIF.sv */
// Line-wide memory read channel
// Requester holds readReq and addr until grant, readValue valid with grant
`timescale 1ns/1ps

interface MemReadIF;

    logic readReq;
    FetchTypes::lineAddr_t addr;
    logic grant;
    FetchTypes::line_t readValue;

    modport requester (
        output readReq,
        output addr,
        input grant,
        input readValue
    );

    modport memory (
        input readReq,
        input addr,
        output grant,
        output readValue
    );

endinterface

/* design/ITlb.sv */
// Fully associative instruction TLB
// Registered vpn lookup, single-word PTE refill over the line port,
// round-robin replacement and single-cycle invalidate
`timescale 1ns/1ps

module ITlb (
    input logic clk,
    input logic rst,
    input FetchTypes::vpn_t lookupVpn,
    input logic lookupEnable,
    output logic hit,
    output logic fault,
    output FetchTypes::ppn_t ppn,
    input logic refillStart,
    input FetchTypes::vpn_t refillVpn,
    input FetchTypes::paddr_t ptBase,
    input logic invalidate,
    output logic refillDone,
    MemReadIF.requester mem
);
    logic [FetchTypes::ITlbEntries-1:0] entryValid;
    logic [FetchTypes::ITlbEntries-1:0] entryFault;
    FetchTypes::vpn_t entryVpn [FetchTypes::ITlbEntries];
    FetchTypes::ppn_t entryPpn [FetchTypes::ITlbEntries];

    logic [FetchTypes::ITlbIndexWidth-1:0] replacePtr;
    logic lookedUp;
    logic busy;
    logic fillNow;
    FetchTypes::vpn_t lookupVpnReg;
    FetchTypes::vpn_t refillVpnReg;
    FetchTypes::paddr_t pteAddr;
    logic [FetchTypes::LineOffsetWidth-FetchTypes::PteSizeLog2-1:0] wordSel;
    FetchTypes::pte_t pteWord;

    // Lookup against the vpn registered last cycle
    always_comb begin
        hit = 1'b0;
        fault = 1'b0;
        ppn = '0;
        for (int i = 0; i < FetchTypes::ITlbEntries; i++) begin
            if (entryValid[i] && entryVpn[i] == lookupVpnReg) begin
                hit = lookedUp;
                fault = entryFault[i];
                ppn = entryPpn[i];
            end
        end
    end

    // PTE word within the returned line
    always_comb begin
        wordSel = pteAddr[FetchTypes::LineOffsetWidth-1:FetchTypes::PteSizeLog2];
        pteWord = mem.readValue[wordSel*FetchTypes::PteWidth +: FetchTypes::PteWidth];
        fillNow = busy && mem.grant;
        mem.readReq = busy;
        mem.addr = pteAddr[FetchTypes::PhysicalAddrWidth-1:FetchTypes::LineOffsetWidth];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lookedUp <= 1'b0;
            busy <= 1'b0;
            refillDone <= 1'b0;
            replacePtr <= '0;
            entryValid <= '0;
        end else begin
            lookedUp <= lookupEnable;
            refillDone <= fillNow;
            if (refillStart) begin
                busy <= 1'b1;
            end else if (fillNow) begin
                busy <= 1'b0;
            end
            if (invalidate) begin
                entryValid <= '0;
            end else if (fillNow) begin
                entryValid[replacePtr] <= 1'b1;
                replacePtr <= replacePtr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookupEnable) begin
            lookupVpnReg <= lookupVpn;
        end
        if (refillStart) begin
            refillVpnReg <= refillVpn;
            pteAddr <= ptBase + FetchTypes::paddr_t'({refillVpn, {FetchTypes::PteSizeLog2{1'b0}}});
        end
        if (fillNow) begin
            entryVpn[replacePtr] <= refillVpnReg;
            entryPpn[replacePtr] <= pteWord[FetchTypes::PpnWidth-1:0];
            // Invalid or non-executable page faults on every hit
            entryFault[replacePtr] <= !pteWord[FetchTypes::PteValidBit] ||
                !pteWord[FetchTypes::PteExecBit];
        end
    end

endmodule

/* design/ICacheArray.sv */
// Direct-mapped instruction cache arrays
// Valid flops, tag and data arrays read at the registered index,
// line refill over the memory read port and single-cycle invalidate
`timescale 1ns/1ps

module ICacheArray (
    input logic clk,
    input logic rst,
    input FetchTypes::cacheIndex_t index,
    input FetchTypes::cacheTag_t lookupTag,
    output logic hit,
    output FetchTypes::line_t line,
    input logic refillStart,
    input FetchTypes::lineAddr_t refillAddr,
    input logic invalidate,
    output logic refillDone,
    MemReadIF.requester mem
);
    logic [FetchTypes::ICacheLines-1:0] validBits;
    FetchTypes::cacheTag_t tagArray [FetchTypes::ICacheLines];
    FetchTypes::line_t dataArray [FetchTypes::ICacheLines];

    FetchTypes::cacheIndex_t indexReg;
    FetchTypes::lineAddr_t refillAddrReg;
    FetchTypes::cacheIndex_t fillIndex;
    FetchTypes::cacheTag_t fillTag;
    logic busy;
    logic fillNow;

    always_comb begin
        hit = validBits[indexReg] && tagArray[indexReg] == lookupTag;
        line = dataArray[indexReg];
    end

    // Line address splits into tag and index
    always_comb begin
        fillIndex = refillAddrReg[FetchTypes::ICacheIndexWidth-1:0];
        fillTag = refillAddrReg[FetchTypes::LineAddrWidth-1:FetchTypes::ICacheIndexWidth];
        fillNow = busy && mem.grant;
        mem.readReq = busy;
        mem.addr = refillAddrReg;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            refillDone <= 1'b0;
            validBits <= '0;
        end else begin
            refillDone <= fillNow;
            if (refillStart) begin
                busy <= 1'b1;
            end else if (fillNow) begin
                busy <= 1'b0;
            end
            if (invalidate) begin
                validBits <= '0;
            end else if (fillNow) begin
                validBits[fillIndex] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        indexReg <= index;
        if (refillStart) begin
            refillAddrReg <= refillAddr;
        end
        if (fillNow) begin
            tagArray[fillIndex] <= fillTag;
            dataArray[fillIndex] <= mem.readValue;
        end
    end

endmodule

/* design/FetchControl.sv */
// Fetch control
// Program counter, fetch FSM, TLB and cache hit combination,
// refill start and routing of the shared memory read port,
// deferred invalidate during refills
`timescale 1ns/1ps

module FetchControl (
    input logic clk,
    input logic rst,
    input logic redirect,
    input FetchTypes::vaddr_t redirectPc,
    input logic stall,
    input logic invalidateReq,
    output FetchTypes::vpn_t tlbLookupVpn,
    output logic tlbLookupEnable,
    input logic tlbHit,
    input logic tlbFault,
    input FetchTypes::ppn_t tlbPpn,
    output logic tlbRefillStart,
    output FetchTypes::vpn_t tlbRefillVpn,
    input logic tlbRefillDone,
    output FetchTypes::cacheIndex_t cacheIndex,
    output FetchTypes::cacheTag_t cacheLookupTag,
    input logic cacheHit,
    input FetchTypes::line_t cacheLine,
    output logic cacheRefillStart,
    output FetchTypes::lineAddr_t cacheRefillAddr,
    input logic cacheRefillDone,
    MemReadIF.memory tlbMem,
    MemReadIF.memory cacheMem,
    output logic memReadReq,
    output FetchTypes::lineAddr_t memAddr,
    input logic memGrant,
    input FetchTypes::line_t memReadValue,
    output logic fetchValid,
    output logic fetchFault,
    output FetchTypes::vaddr_t fetchPc,
    output FetchTypes::line_t fetchLine,
    output logic invalidate
);
    FetchTypes::FetchState state;
    FetchTypes::FetchState nextState;
    FetchTypes::vaddr_t pcReg;
    FetchTypes::vaddr_t nextPc;
    FetchTypes::paddr_t physPc;
    logic lookupValid;
    logic lookupActive;
    logic pendingInvalidate;
    logic refillFinishing;

    // Hit and miss combination for the pc looked up last cycle
    always_comb begin
        physPc = {tlbPpn, pcReg[FetchTypes::PageOffsetWidth-1:0]};
        lookupActive = state == FetchTypes::Fetch && lookupValid && !redirect;
        fetchValid = lookupActive && tlbHit && (tlbFault || cacheHit);
        fetchFault = lookupActive && tlbHit && tlbFault;
        fetchPc = pcReg;
        fetchLine = cacheLine;

        // TLB refill takes priority over cache refill
        tlbRefillStart = lookupActive && !tlbHit;
        tlbRefillVpn = pcReg[FetchTypes::VirtualAddrWidth-1:FetchTypes::PageOffsetWidth];
        cacheRefillStart = lookupActive && tlbHit && !tlbFault && !cacheHit;
        cacheRefillAddr = physPc[FetchTypes::PhysicalAddrWidth-1:FetchTypes::LineOffsetWidth];
        cacheLookupTag = physPc[FetchTypes::PhysicalAddrWidth-1:
            FetchTypes::LineOffsetWidth+FetchTypes::ICacheIndexWidth];
    end

    always_comb begin
        if (redirect) begin
            nextPc = redirectPc;
        end else if (fetchValid && !stall) begin
            nextPc = pcReg + FetchTypes::InsnSize;
        end else begin
            nextPc = pcReg;
        end
    end

    always_comb begin
        case (state)
            FetchTypes::RefillTlb: begin
                nextState = tlbRefillDone ? FetchTypes::Fetch : FetchTypes::RefillTlb;
            end
            FetchTypes::RefillCache: begin
                nextState = cacheRefillDone ? FetchTypes::Fetch : FetchTypes::RefillCache;
            end
            default: begin
                if (tlbRefillStart) begin
                    nextState = FetchTypes::RefillTlb;
                end else if (cacheRefillStart) begin
                    nextState = FetchTypes::RefillCache;
                end else begin
                    nextState = FetchTypes::Fetch;
                end
            end
        endcase
    end

    // Next lookup, index bits lie inside the page offset
    always_comb begin
        tlbLookupVpn = nextPc[FetchTypes::VirtualAddrWidth-1:FetchTypes::PageOffsetWidth];
        tlbLookupEnable = nextState == FetchTypes::Fetch;
        cacheIndex = nextPc[FetchTypes::LineOffsetWidth+FetchTypes::ICacheIndexWidth-1:
            FetchTypes::LineOffsetWidth];
    end

    // Invalidate at once in Fetch, otherwise when the refill ends
    always_comb begin
        refillFinishing = (state == FetchTypes::RefillTlb && tlbRefillDone) ||
            (state == FetchTypes::RefillCache && cacheRefillDone);
        if (state == FetchTypes::Fetch) begin
            invalidate = invalidateReq;
        end else begin
            invalidate = refillFinishing && (pendingInvalidate || invalidateReq);
        end
    end

    // Shared memory port follows the state
    always_comb begin
        tlbMem.readValue = memReadValue;
        cacheMem.readValue = memReadValue;
        tlbMem.grant = state == FetchTypes::RefillTlb && memGrant;
        cacheMem.grant = state == FetchTypes::RefillCache && memGrant;
        case (state)
            FetchTypes::RefillTlb: begin
                memReadReq = tlbMem.readReq;
                memAddr = tlbMem.addr;
            end
            FetchTypes::RefillCache: begin
                memReadReq = cacheMem.readReq;
                memAddr = cacheMem.addr;
            end
            default: begin
                memReadReq = 1'b0;
                memAddr = cacheMem.addr;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FetchTypes::Fetch;
            pcReg <= FetchTypes::InitialPc;
            lookupValid <= 1'b0;
            pendingInvalidate <= 1'b0;
        end else begin
            state <= nextState;
            pcReg <= nextPc;
            lookupValid <= tlbLookupEnable;
            pendingInvalidate <= state != FetchTypes::Fetch && !refillFinishing &&
                (pendingInvalidate || invalidateReq);
        end
    end

endmodule

/* design/FetchTop.sv */
// Instruction fetch subsystem top level
// TLB, cache arrays and fetch control joined by two memory read channels
`timescale 1ns/1ps

module FetchTop (
    input logic clk,
    input logic rst,
    input logic redirect,
    input FetchTypes::vaddr_t redirectPc,
    input logic stall,
    input logic invalidate,
    input FetchTypes::paddr_t ptBase,
    output logic memReadReq,
    output FetchTypes::lineAddr_t memAddr,
    input logic memGrant,
    input FetchTypes::line_t memReadValue,
    output logic fetchValid,
    output logic fetchFault,
    output FetchTypes::vaddr_t fetchPc,
    output FetchTypes::line_t fetchLine
);
    FetchTypes::vpn_t tlbLookupVpn;
    logic tlbLookupEnable;
    logic tlbHit;
    logic tlbFault;
    FetchTypes::ppn_t tlbPpn;
    logic tlbRefillStart;
    FetchTypes::vpn_t tlbRefillVpn;
    logic tlbRefillDone;

    FetchTypes::cacheIndex_t cacheIndex;
    FetchTypes::cacheTag_t cacheLookupTag;
    logic cacheHit;
    FetchTypes::line_t cacheLine;
    logic cacheRefillStart;
    FetchTypes::lineAddr_t cacheRefillAddr;
    logic cacheRefillDone;

    logic arrayInvalidate;

    MemReadIF tlbMem ();
    MemReadIF cacheMem ();

    ITlb tlb (
        .clk,
        .rst,
        .lookupVpn(tlbLookupVpn),
        .lookupEnable(tlbLookupEnable),
        .hit(tlbHit),
        .fault(tlbFault),
        .ppn(tlbPpn),
        .refillStart(tlbRefillStart),
        .refillVpn(tlbRefillVpn),
        .ptBase,
        .invalidate(arrayInvalidate),
        .refillDone(tlbRefillDone),
        .mem(tlbMem.requester)
    );

    ICacheArray cache (
        .clk,
        .rst,
        .index(cacheIndex),
        .lookupTag(cacheLookupTag),
        .hit(cacheHit),
        .line(cacheLine),
        .refillStart(cacheRefillStart),
        .refillAddr(cacheRefillAddr),
        .invalidate(arrayInvalidate),
        .refillDone(cacheRefillDone),
        .mem(cacheMem.requester)
    );

    FetchControl control (
        .clk,
        .rst,
        .redirect,
        .redirectPc,
        .stall,
        .invalidateReq(invalidate),
        .tlbLookupVpn,
        .tlbLookupEnable,
        .tlbHit,
        .tlbFault,
        .tlbPpn,
        .tlbRefillStart,
        .tlbRefillVpn,
        .tlbRefillDone,
        .cacheIndex,
        .cacheLookupTag,
        .cacheHit,
        .cacheLine,
        .cacheRefillStart,
        .cacheRefillAddr,
        .cacheRefillDone,
        .tlbMem(tlbMem.memory),
        .cacheMem(cacheMem.memory),
        .memReadReq,
        .memAddr,
        .memGrant,
        .memReadValue,
        .fetchValid,
        .fetchFault,
        .fetchPc,
        .fetchLine,
        .invalidate(arrayInvalidate)
    );

endmodule

/* tb/FetchClockGen.sv */
// Free-running testbench clock, 4 ns period
`timescale 1ns/1ps

module FetchClockGen (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #2 clk = ~clk;
    end

endmodule

/* tb/fetchTop_assertions.sv */
// Concurrent checks on the fetch subsystem top-level ports
// Memory request handshake, fault qualification and reset state,
// bound into every FetchTop instance
`timescale 1ns/1ps

module FetchTopAssertions (
    input logic clk,
    input logic rst,
    input logic memReadReq,
    input FetchTypes::lineAddr_t memAddr,
    input logic memGrant,
    input logic fetchValid,
    input logic fetchFault
);

    // Pending read keeps its address until the grant
    addrHeldUntilGrant: assert property (
        @(posedge clk) disable iff (rst)
        memReadReq && !memGrant |=> memReadReq && $stable(memAddr)
    ) else $error("memAddr changed or memReadReq dropped before the grant");

    faultOnlyWithValid: assert property (
        @(posedge clk) disable iff (rst)
        fetchFault |-> fetchValid
    ) else $error("fetchFault high without fetchValid");

    // First cycle out of reset
    quietAfterReset: assert property (
        @(posedge clk)
        $fell(rst) |-> !fetchValid && !memReadReq
    ) else $error("fetchValid or memReadReq high right after reset");

    reqDropsAfterGrant: assert property (
        @(posedge clk) disable iff (rst)
        memReadReq && memGrant |=> !memReadReq
    ) else $error("memReadReq stayed high in the cycle after a grant");

endmodule

bind FetchTop FetchTopAssertions portChecks (
    .clk,
    .rst,
    .memReadReq,
    .memAddr,
    .memGrant,
    .fetchValid,
    .fetchFault
);

/* tb/FetchTb.sv */
// Directed testbench for the instruction fetch subsystem
// Line memory model with random grant latency, page table setup,
// typed check tasks, one task per test and the run summary
`timescale 1ns/1ps

module FetchTb;

    localparam FetchTypes::paddr_t PtBase = 24'h08_0000;
    localparam int WaitLimit = 200;
    localparam int LinesPerPage = 1 << (FetchTypes::PageOffsetWidth - FetchTypes::LineOffsetWidth);

    logic clk;
    logic rst;
    logic redirect;
    FetchTypes::vaddr_t redirectPc;
    logic stall;
    logic invalidate;
    FetchTypes::paddr_t ptBase;
    logic memReadReq;
    FetchTypes::lineAddr_t memAddr;
    logic memGrant;
    FetchTypes::line_t memReadValue;
    logic fetchValid;
    logic fetchFault;
    FetchTypes::vaddr_t fetchPc;
    FetchTypes::line_t fetchLine;

    FetchTypes::line_t lineStore [FetchTypes::lineAddr_t];
    int unsigned grantDelay;
    int checkCount;
    int errorCount;
    logic timedOut;
    FetchTypes::vaddr_t expectPc;

    FetchClockGen clockGen (
        .clk
    );

    FetchTop dut (.*);

    // Lines never written return a pattern built from their address
    function automatic FetchTypes::line_t fillPattern(input FetchTypes::lineAddr_t addr);
        return {addr ^ 20'h5a5a5, 12'hc0d, addr, 12'h0de, ~addr, 12'hf00, addr, 12'h123};
    endfunction

    function automatic FetchTypes::line_t readLine(input FetchTypes::lineAddr_t addr);
        if (lineStore.exists(addr)) begin
            return lineStore[addr];
        end
        return fillPattern(addr);
    endfunction

    function automatic FetchTypes::pte_t makePte(input logic valid, input logic exec,
                                                 input FetchTypes::ppn_t ppn);
        return {valid, exec, 18'd0, ppn};
    endfunction

    function automatic FetchTypes::pte_t readPte(input FetchTypes::vpn_t vpn);
        FetchTypes::paddr_t pteAddr;
        FetchTypes::line_t pteLine;
        pteAddr = PtBase + FetchTypes::paddr_t'({vpn, 2'b00});
        pteLine = readLine(pteAddr[23:4]);
        return pteLine[pteAddr[3:2] * 32 +: 32];
    endfunction

    function automatic logic expectedFault(input FetchTypes::vaddr_t pc);
        FetchTypes::pte_t pte;
        pte = readPte(pc[31:12]);
        return !pte[31] || !pte[30];
    endfunction

    function automatic FetchTypes::line_t expectedLine(input FetchTypes::vaddr_t pc);
        FetchTypes::pte_t pte;
        pte = readPte(pc[31:12]);
        return readLine({pte[11:0], pc[11:4]});
    endfunction

    task automatic writePte(input FetchTypes::vpn_t vpn, input FetchTypes::pte_t pte);
        FetchTypes::paddr_t pteAddr;
        FetchTypes::line_t pteLine;
        pteAddr = PtBase + FetchTypes::paddr_t'({vpn, 2'b00});
        pteLine = readLine(pteAddr[23:4]);
        pteLine[pteAddr[3:2] * 32 +: 32] = pte;
        lineStore[pteAddr[23:4]] = pteLine;
    endtask

    task automatic fillCode(input FetchTypes::ppn_t ppn);
        for (int i = 0; i < LinesPerPage; i++) begin
            lineStore[{ppn, i[7:0]}] = {$urandom, $urandom, $urandom, $urandom};
        end
    endtask

    task automatic setupMemory();
        writePte(20'h00001, makePte(1'b1, 1'b1, 12'h021));
        writePte(20'h00002, makePte(1'b1, 1'b1, 12'h02e));
        writePte(20'h00003, makePte(1'b1, 1'b1, 12'h013));
        writePte(20'h00004, makePte(1'b1, 1'b1, 12'h0a4));
        writePte(20'h00005, makePte(1'b1, 1'b1, 12'h047));
        // Readable but not executable, then not valid at all
        writePte(20'h00006, makePte(1'b1, 1'b0, 12'h066));
        writePte(20'h00007, makePte(1'b0, 1'b1, 12'h077));
        writePte(20'h00008, makePte(1'b1, 1'b1, 12'h058));
        fillCode(12'h021);
        fillCode(12'h02e);
        fillCode(12'h013);
        fillCode(12'h0a4);
        fillCode(12'h047);
        fillCode(12'h058);
        fillCode(12'h06a);
    endtask

    // Grant after 1 to 6 cycles of a held request
    always @(posedge clk) begin
        #1;
        if (rst || memGrant) begin
            memGrant = 1'b0;
            grantDelay = 0;
        end else if (memReadReq) begin
            if (grantDelay == 0) begin
                grantDelay = 1 + $urandom % 6;
            end
            grantDelay = grantDelay - 1;
            if (grantDelay == 0) begin
                memGrant = 1'b1;
                memReadValue = readLine(memAddr);
            end
        end
    end

    task automatic checkPc(input string what, input FetchTypes::vaddr_t got,
                           input FetchTypes::vaddr_t want);
        checkCount++;
        if (got !== want) begin
            errorCount++;
            $display("mismatch at %0t ns: %s pc %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic checkLine(input string what, input FetchTypes::line_t got,
                             input FetchTypes::line_t want);
        checkCount++;
        if (got !== want) begin
            errorCount++;
            $display("mismatch at %0t ns: %s line %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic checkFault(input string what, input logic got, input logic want);
        checkCount++;
        if (got !== want) begin
            errorCount++;
            $display("mismatch at %0t ns: %s fault %b, expected %b", $time, what, got, want);
        end
    endtask

    // Outputs are sampled at the falling edge, away from input changes
    task automatic waitDelivery(output logic ok);
        int cycles;
        ok = 1'b0;
        cycles = 0;
        while (!ok && !timedOut) begin
            @(negedge clk);
            if (fetchValid && !stall) begin
                ok = 1'b1;
            end else begin
                cycles++;
                if (cycles >= WaitLimit) begin
                    timedOut = 1'b1;
                    $display("no fetch was delivered within %0d cycles, stopped at %0t ns",
                        WaitLimit, $time);
                end
            end
        end
    endtask

    task automatic fetchAndCheck(input string what, input FetchTypes::vaddr_t pc);
        logic ok;
        waitDelivery(ok);
        if (ok) begin
            checkPc(what, fetchPc, pc);
            checkFault(what, fetchFault, expectedFault(pc));
            if (!expectedFault(pc)) begin
                checkLine(what, fetchLine, expectedLine(pc));
            end
        end
    endtask

    task automatic runSequence(input string what, input FetchTypes::vaddr_t startPc,
                               input int count);
        expectPc = startPc;
        for (int i = 0; i < count && !timedOut; i++) begin
            fetchAndCheck(what, expectPc);
            expectPc = expectPc + FetchTypes::InsnSize;
        end
    endtask

    task automatic redirectTo(input FetchTypes::vaddr_t pc);
        @(posedge clk);
        #1;
        redirect = 1'b1;
        redirectPc = pc;
        @(posedge clk);
        #1;
        redirect = 1'b0;
    endtask

    task automatic invalidateAndRedirect(input FetchTypes::vaddr_t pc);
        @(posedge clk);
        #1;
        invalidate = 1'b1;
        redirect = 1'b1;
        redirectPc = pc;
        @(posedge clk);
        #1;
        invalidate = 1'b0;
        redirect = 1'b0;
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        $display("test %s finished with %0d errors%s", name, errorCount - errorsBefore,
            timedOut ? " after a timeout" : "");
    endtask

    task automatic sequentialTest();
        int errorsBefore;
        errorsBefore = errorCount;
        // Runs from page 1 well into page 2
        runSequence("sequential", FetchTypes::InitialPc, 1024 + 32);
        reportTest("sequential", errorsBefore);
    endtask

    task automatic stallTest();
        int errorsBefore;
        errorsBefore = errorCount;
        for (int round = 0; round < 3 && !timedOut; round++) begin
            @(posedge clk);
            #1;
            stall = 1'b1;
            repeat (4 + 3 * round) begin
                @(negedge clk);
                if (fetchValid) begin
                    checkPc("held by stall", fetchPc, expectPc);
                end
            end
            @(posedge clk);
            #1;
            stall = 1'b0;
            runSequence("after stall", expectPc, 5);
        end
        reportTest("stall", errorsBefore);
    endtask

    task automatic redirectTest();
        int errorsBefore;
        errorsBefore = errorCount;
        redirectTo(32'h0000_5ab4);
        runSequence("redirect", 32'h0000_5ab4, 12);
        redirectTo(32'h0000_1010);
        runSequence("redirect back", 32'h0000_1010, 4);
        reportTest("redirect", errorsBefore);
    endtask

    task automatic faultTest();
        int errorsBefore;
        errorsBefore = errorCount;
        redirectTo(32'h0000_6000);
        runSequence("no exec page", 32'h0000_6000, 3);
        // Last two words of an invalid page, then a valid page
        redirectTo(32'h0000_7ff8);
        runSequence("invalid page", 32'h0000_7ff8, 4);
        reportTest("fault", errorsBefore);
    endtask

    task automatic invalidateTest();
        int errorsBefore;
        FetchTypes::lineAddr_t codeAddr;
        errorsBefore = errorCount;
        codeAddr = {12'h058, 8'h04};
        redirectTo(32'h0000_8040);
        runSequence("before invalidate", 32'h0000_8040, 1);
        lineStore[codeAddr] = ~readLine(codeAddr);
        invalidateAndRedirect(32'h0000_8040);
        runSequence("new line", 32'h0000_8040, 2);
        writePte(20'h00008, makePte(1'b1, 1'b1, 12'h06a));
        invalidateAndRedirect(32'h0000_8040);
        runSequence("new translation", 32'h0000_8040, 2);
        reportTest("invalidate", errorsBefore);
    endtask

    task automatic longRunTest();
        int errorsBefore;
        errorsBefore = errorCount;
        redirectTo(32'h0000_3e00);
        runSequence("long run", 32'h0000_3e00, 768);
        reportTest("long run", errorsBefore);
    endtask

    initial begin
        void'($urandom(32'h9db));
        rst = 1'b1;
        redirect = 1'b0;
        redirectPc = '0;
        stall = 1'b0;
        invalidate = 1'b0;
        ptBase = PtBase;
        memGrant = 1'b0;
        memReadValue = '0;
        grantDelay = 0;
        checkCount = 0;
        errorCount = 0;
        timedOut = 1'b0;
        expectPc = FetchTypes::InitialPc;
        setupMemory();

        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        sequentialTest();
        if (!timedOut) begin
            stallTest();
        end
        if (!timedOut) begin
            redirectTest();
        end
        if (!timedOut) begin
            faultTest();
        end
        if (!timedOut) begin
            invalidateTest();
        end
        if (!timedOut) begin
            longRunTest();
        end

        $display("summary: %0d checks, %0d errors, timeout %s", checkCount, errorCount,
            timedOut ? "yes" : "no");
        if (errorCount == 0 && !timedOut) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* fetchSubsystem.f */
design/FetchTypes.sv
design/MemReadIF.sv
design/ITlb.sv
design/ICacheArray.sv
design/FetchControl.sv
design/FetchTop.sv
tb/FetchClockGen.sv
tb/fetchTop_assertions.sv
tb/FetchTb.sv

/* runSim.sh */
#!/bin/sh
# Build the fetch subsystem testbench with Verilator and run it.
# Exit status is nonzero when the log reports a failure.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f fetchSubsystem.f \
    --top-module FetchTb \
    -o fetchSim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/fetchSim > sim.log 2>&1 \
    || { cat sim.log; echo "simulation exited with an error"; exit 1; }

cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0
